// ==== source/valu_pkg.sv ====
`default_nettype none

package valu_pkg;

	// Operand and result width, fixed by the instruction encoding
	localparam int DATA_W = 64;

	// Bit 0 is the MSB, lane 0 sits at the left
	typedef logic [0:DATA_W-1] vec_t;

	// Major opcodes, instruction bits 0:5
	typedef enum logic [5:0] {
		LOAD      = 6'b100000,
		STORE     = 6'b100001,
		BRANCH_EZ = 6'b100010,
		BRANCH_NZ = 6'b100011,
		R_ALU     = 6'b101010,
		NOP       = 6'b111100
	} op_code_e;

	// R-type function codes, instruction bits 26:31
	// Shift, divide and square codes only decode, to a zero result
	typedef enum logic [5:0] {
		VNOP = 6'd0, VAND = 6'd1, VOR = 6'd2, VXOR = 6'd3, VNOT = 6'd4,
		VMOV = 6'd5, VADD = 6'd6, VSUB = 6'd7, VMULEU = 6'd8, VMULOU = 6'd9,
		VSLL = 6'd10, VSRL = 6'd11, VSRA = 6'd12, VRTTH = 6'd13, VDIV = 6'd14,
		VMOD = 6'd15, VSQEU = 6'd16, VSQOU = 6'd17, VSQRT = 6'd18
	} r_func_e;

	// Lane width, WW field
	typedef enum logic [1:0] {
		W8  = 2'b00,
		W16 = 2'b01,
		W32 = 2'b10,
		W64 = 2'b11
	} lane_w_e;

	// Which execution unit supplies the result
	typedef enum logic [1:0] {
		UNIT_LOGIC  = 2'd0,
		UNIT_ADDSUB = 2'd1,
		UNIT_MUL    = 2'd2,
		UNIT_ZERO   = 2'd3
	} unit_sel_e;

	// Incoming request, 142 bits
	typedef struct packed {
		op_code_e op_code;
		r_func_e  r_func;
		lane_w_e  lane_w;
		vec_t     ra;
		vec_t     rb;
	} valu_req_t;

	// Registered bundle from the controller
	typedef struct packed {
		unit_sel_e unit;
		r_func_e   r_func;
		lane_w_e   lane_w;
		vec_t      ra;
		vec_t      rb;
	} valu_issue_t;

endpackage

`default_nettype wire

// ==== source/valu_ctrl.sv ====
`default_nettype none

module valu_ctrl
	import valu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        req_valid,
	input  valu_req_t   req,
	output logic        issue_valid,
	output valu_issue_t issue
);

	unit_sel_e dec_unit;
	logic      accept;

	// Only R-type ALU requests go down the pipe
	assign accept = req_valid && (req.op_code == R_ALU);

	// Function code to execution unit
	always_comb begin
		case (req.r_func)
			VAND, VOR, VXOR, VNOT, VMOV, VRTTH: dec_unit = UNIT_LOGIC;
			VADD, VSUB:                         dec_unit = UNIT_ADDSUB;
			VMULEU, VMULOU:                     dec_unit = UNIT_MUL;
			// VNOP, dropped and unknown codes
			default:                            dec_unit = UNIT_ZERO;
		endcase
	end

	// Valid strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= accept;
		end
	end

	// Bundle only loads on an accepted request
	always_ff @(posedge clk) begin
		if (accept) begin
			issue.unit   <= dec_unit;
			issue.r_func <= req.r_func;
			issue.lane_w <= req.lane_w;
			issue.ra     <= req.ra;
			issue.rb     <= req.rb;
		end
	end

endmodule

`default_nettype wire

// ==== source/valu_logic_unit.sv ====
`default_nettype none

module valu_logic_unit
	import valu_pkg::*;
(
	input  valu_issue_t issue,
	output vec_t        logic_res
);

	logic [5:0] half_w;
	vec_t       rtth;

	// Half a lane in bits, 4 for W8 up to 32 for W64
	assign half_w = 6'd4 << issue.lane_w;

	// Lanes are aligned, so flipping the half bit of the index swaps the halves
	always_comb begin
		for (int b = 0; b < DATA_W; b++) begin
			rtth[b] = issue.ra[b ^ int'(half_w)];
		end
	end

	always_comb begin
		case (issue.r_func)
			VAND:    logic_res = issue.ra & issue.rb;
			VOR:     logic_res = issue.ra | issue.rb;
			VXOR:    logic_res = issue.ra ^ issue.rb;
			// Single operand ops use ra only
			VNOT:    logic_res = ~issue.ra;
			VMOV:    logic_res = issue.ra;
			VRTTH:   logic_res = rtth;
			default: logic_res = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/valu_addsub_unit.sv ====
`default_nettype none

module valu_addsub_unit
	import valu_pkg::*;
(
	input  valu_issue_t issue,
	output vec_t        addsub_res
);

	logic       is_sub;
	vec_t       b_op;
	logic [2:0] lane_mask;

	assign is_sub = (issue.r_func == VSUB);

	// Subtract is a plus the ones complement of b plus one per lane
	assign b_op = is_sub ? ~issue.rb : issue.rb;

	// Bytes per lane minus one, 0 for W8 up to 7 for W64
	assign lane_mask = 3'((4'd1 << issue.lane_w) - 4'd1);

	// Eight byte slices, carry ripples from slice 7 (LSB) toward slice 0
	always_comb begin
		logic       cin;
		logic [8:0] sum;
		cin = 1'b0;
		sum = '0;
		addsub_res = '0;
		for (int s = 7; s >= 0; s--) begin
			// Lowest byte of a lane, kill the carry from the lane to the right
			if ((3'(s + 1) & lane_mask) == 3'd0) begin
				cin = is_sub;
			end
			sum = {1'b0, issue.ra[s*8 +: 8]} + {1'b0, b_op[s*8 +: 8]} + 9'(cin);
			addsub_res[s*8 +: 8] = sum[7:0];
			cin = sum[8];
		end
	end

endmodule

`default_nettype wire

// ==== source/valu_mul_unit.sv ====
`default_nettype none

module valu_mul_unit
	import valu_pkg::*;
(
	input  valu_issue_t issue,
	output vec_t        mul_res
);

	logic is_mul;
	logic odd;

	assign is_mul = (issue.r_func == VMULEU) || (issue.r_func == VMULOU);

	// 0 picks lanes 0,2,4..; 1 picks lanes 1,3,5..
	assign odd = (issue.r_func == VMULOU);

	// Product of lane pair p lands in the double-width slot p
	always_comb begin
		mul_res = '0;
		if (is_mul) begin
			case (issue.lane_w)
				W8: begin
					for (int p = 0; p < 4; p++) begin
						mul_res[p*16 +: 16] = 16'(issue.ra[(2*p + int'(odd))*8 +: 8])
							* 16'(issue.rb[(2*p + int'(odd))*8 +: 8]);
					end
				end
				W16: begin
					for (int p = 0; p < 2; p++) begin
						mul_res[p*32 +: 32] = 32'(issue.ra[(2*p + int'(odd))*16 +: 16])
							* 32'(issue.rb[(2*p + int'(odd))*16 +: 16]);
					end
				end
				W32: begin
					// One pair only
					mul_res = 64'(issue.ra[int'(odd)*32 +: 32])
						* 64'(issue.rb[int'(odd)*32 +: 32]);
				end
				// No 128 bit product, stays zero
				default: mul_res = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/valu_result_stage.sv ====
`default_nettype none

module valu_result_stage
	import valu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      issue_valid,
	input  unit_sel_e unit,
	input  vec_t      logic_res,
	input  vec_t      addsub_res,
	input  vec_t      mul_res,
	output logic      res_valid,
	output vec_t      res
);

	vec_t sel_res;

	// Unit select
	always_comb begin
		case (unit)
			UNIT_LOGIC:  sel_res = logic_res;
			UNIT_ADDSUB: sel_res = addsub_res;
			UNIT_MUL:    sel_res = mul_res;
			default:     sel_res = '0;
		endcase
	end

	// Output register, res holds between results
	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			res       <= '0;
		end else begin
			res_valid <= issue_valid;
			if (issue_valid) begin
				res <= sel_res;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/valu_top.sv ====
`default_nettype none

module valu_top
	import valu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      req_valid,
	input  valu_req_t req,
	output logic      res_valid,
	output vec_t      res
);

	logic        issue_valid;
	valu_issue_t issue;
	vec_t        logic_res;
	vec_t        addsub_res;
	vec_t        mul_res;

	// Stage 1, decode and issue register
	valu_ctrl i_ctrl (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req         (req),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

	// Execution units, all combinational off the issue register
	valu_logic_unit i_logic_unit (
		.issue     (issue),
		.logic_res (logic_res)
	);

	valu_addsub_unit i_addsub_unit (
		.issue      (issue),
		.addsub_res (addsub_res)
	);

	valu_mul_unit i_mul_unit (
		.issue   (issue),
		.mul_res (mul_res)
	);

	// Stage 2, result mux and output register
	valu_result_stage i_result_stage (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.unit        (issue.unit),
		.logic_res   (logic_res),
		.addsub_res  (addsub_res),
		.mul_res     (mul_res),
		.res_valid   (res_valid),
		.res         (res)
	);

endmodule

`default_nettype wire

// ==== verif/valu_checker.sv ====
`default_nettype none

module valu_checker
	import valu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic res_valid,
	input vec_t res
);

	// Expected results, oldest first
	string q_name[$];
	vec_t  q_exp[$];
	int    q_due[$];
	int    cyc = 0;
	int    errors = 0;
	int    checked = 0;

	// Rising edge count
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// Result due two cycles after the request is driven
	task automatic push_expected(input string name, input vec_t exp);
		q_name.push_back(name);
		q_exp.push_back(exp);
		q_due.push_back(cyc + 2);
	endtask

	// Sample mid cycle, outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && res_valid) begin
			if (q_exp.size() == 0) begin
				errors++;
				$display("Result %h arrived at cycle %0d with no request pending", res, cyc);
			end else begin
				checked++;
				if (res !== q_exp[0]) begin
					errors++;
					$display("[ERROR] %s: expected %h, actual %h", q_name[0], q_exp[0], res);
				end
				if (q_due[0] != cyc) begin
					errors++;
					$display("%s: result came at cycle %0d, due at cycle %0d", q_name[0], cyc,
						q_due[0]);
				end
				void'(q_name.pop_front());
				void'(q_exp.pop_front());
				void'(q_due.pop_front());
			end
		end
		// Past due and never seen
		while (q_due.size() != 0 && q_due[0] < cyc) begin
			errors++;
			$display("%s: no result by cycle %0d", q_name[0], q_due[0]);
			void'(q_name.pop_front());
			void'(q_exp.pop_front());
			void'(q_due.pop_front());
		end
	end

	// Block until every expected result is seen or the limit runs out
	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (q_exp.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (q_exp.size() != 0) begin
			errors += q_exp.size();
			$display("Timeout: %0d expected results never arrived", q_exp.size());
		end
	endtask

endmodule

`default_nettype wire

// ==== verif/valu_tb.sv ====
`default_nettype none

module valu_tb
	import valu_pkg::*;
();

	localparam vec_t A = 64'h0123_4567_89ab_cdef;
	localparam vec_t B = 64'hff00_f0f0_cc33_5a5a;
	localparam vec_t ONES = '1;
	// Multiply operands
	localparam vec_t M8A = 64'h0205_0307_ff11_1004;
	localparam vec_t M8B = 64'h0306_0408_ff22_1005;
	localparam vec_t M16A = 64'hffff_0002_1234_0010;
	localparam vec_t M16B = 64'hffff_0003_0010_0100;
	localparam vec_t M32 = 64'hffff_ffff_0001_0000;

	logic      clk;
	logic      rst;
	logic      req_valid;
	valu_req_t req;
	logic      res_valid;
	vec_t      res;

	// Stimulus table, one row per request
	string     t_name[$];
	valu_req_t t_req[$];
	vec_t      t_exp[$];

	valu_top i_dut (.clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
		.res_valid(res_valid), .res(res));

	valu_checker i_checker (.clk(clk), .rst(rst), .res_valid(res_valid), .res(res));

	task automatic add_entry(input string name, input op_code_e op, input r_func_e fn,
		input lane_w_e w, input vec_t ra, input vec_t rb, input vec_t exp);
		valu_req_t r;
		r = '{op_code: op, r_func: fn, lane_w: w, ra: ra, rb: rb};
		t_name.push_back(name);
		t_req.push_back(r);
		t_exp.push_back(exp);
	endtask

	// Each lane wraps on its own
	function automatic vec_t lane_addsub(input vec_t ra, input vec_t rb, input int bits,
		input bit sub);
		logic [63:0] mask;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] r;
		mask = (bits == 64) ? '1 : (64'd1 << bits) - 64'd1;
		r = '0;
		for (int sh = 0; sh < 64; sh += bits) begin
			a = (64'(ra) >> sh) & mask;
			b = (64'(rb) >> sh) & mask;
			r = r | (((sub ? a - b : a + b) & mask) << sh);
		end
		return r;
	endfunction

	task automatic build_table();
		vec_t ra;
		vec_t rb;
		bit   sub;
		// Non ALU opcodes first, nothing may come out
		add_entry("load", LOAD, VADD, W8, A, B, '0);
		add_entry("store", STORE, VAND, W16, A, B, '0);
		add_entry("and_w8", R_ALU, VAND, W8, A, B, 64'h0100_4060_8823_484a);
		add_entry("or_w16", R_ALU, VOR, W16, A, B, 64'hff23_f5f7_cdbb_dfff);
		add_entry("xor_w32", R_ALU, VXOR, W32, A, B, 64'hfe23_b597_4598_97b5);
		add_entry("not_w64", R_ALU, VNOT, W64, A, B, 64'hfedc_ba98_7654_3210);
		add_entry("mov_w8", R_ALU, VMOV, W8, A, B, A);
		// Halves of each lane trade places
		add_entry("rtth_w8", R_ALU, VRTTH, W8, A, B, 64'h1032_5476_98ba_dcfe);
		add_entry("rtth_w16", R_ALU, VRTTH, W16, A, B, 64'h2301_6745_ab89_efcd);
		add_entry("rtth_w32", R_ALU, VRTTH, W32, A, B, 64'h4567_0123_cdef_89ab);
		add_entry("rtth_w64", R_ALU, VRTTH, W64, A, B, 64'h89ab_cdef_0123_4567);
		add_entry("brez", BRANCH_EZ, VAND, W8, A, B, '0);
		// All ones plus one per lane
		add_entry("add_w8", R_ALU, VADD, W8, ONES, 64'h0101_0101_0101_0101, '0);
		add_entry("add_w32", R_ALU, VADD, W32, ONES, 64'h0000_0001_0000_0001, '0);
		add_entry("add_w8_ab", R_ALU, VADD, W8, A, B, 64'h0023_3557_55de_2749);
		// Zero minus one per lane
		add_entry("sub_w16", R_ALU, VSUB, W16, '0, 64'h0001_0001_0001_0001, ONES);
		add_entry("sub_w64", R_ALU, VSUB, W64, '0, 64'd1, ONES);
		add_entry("nop_op", NOP, VSUB, W8, A, B, '0);
		add_entry("muleu_w8", R_ALU, VMULEU, W8, M8A, M8B, 64'h0006_000c_fe01_0100);
		add_entry("mulou_w8", R_ALU, VMULOU, W8, M8A, M8B, 64'h001e_0038_0242_0014);
		add_entry("muleu_w16", R_ALU, VMULEU, W16, M16A, M16B, 64'hfffe_0001_0001_2340);
		add_entry("mulou_w16", R_ALU, VMULOU, W16, M16A, M16B, 64'h0000_0006_0000_1000);
		add_entry("muleu_w32", R_ALU, VMULEU, W32, M32, M32, 64'hffff_fffe_0000_0001);
		add_entry("mulou_w32", R_ALU, VMULOU, W32, M32, M32, 64'h0000_0001_0000_0000);
		add_entry("muleu_w64", R_ALU, VMULEU, W64, M32, M32, '0);
		add_entry("brnz", BRANCH_NZ, VMULEU, W32, M32, M32, '0);
		// VNOP and dropped codes read as zero
		add_entry("vnop", R_ALU, VNOP, W8, A, B, '0);
		add_entry("vdiv", R_ALU, VDIV, W16, A, B, '0);
		add_entry("vsll", R_ALU, VSLL, W8, A, B, '0);
		// Random add and subtract at every width
		for (int k = 0; k < 4; k++) begin
			for (int i = 0; i < 8; i++) begin
				ra = {$urandom, $urandom};
				rb = {$urandom, $urandom};
				sub = ($urandom & 32'd1) != 0;
				add_entry($sformatf("rand_w%0d_%0d", 8 << k, i), R_ALU, sub ? VSUB : VADD,
					lane_w_e'(2'(k)), ra, rb, lane_addsub(ra, rb, 8 << k, sub));
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run limit
	initial begin
		repeat (2000) @(posedge clk);
		$display("Timeout: the run did not finish within 2000 cycles");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		void'($urandom(32'hf039256f));
		build_table();
		repeat (5) @(posedge clk);
		#2 rst = 1'b0;
		// One row per cycle, back to back
		foreach (t_req[i]) begin
			req_valid = 1'b1;
			req = t_req[i];
			if (t_req[i].op_code == R_ALU) begin
				i_checker.push_expected(t_name[i], t_exp[i]);
			end
			@(posedge clk);
			#2;
		end
		req_valid = 1'b0;
		req = '0;
		i_checker.wait_drain(10);
		// Window for stray results
		repeat (4) @(posedge clk);
		$display("Results checked: %0d, errors: %0d", i_checker.checked, i_checker.errors);
		if (i_checker.errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/valu_pkg.sv
source/valu_ctrl.sv
source/valu_logic_unit.sv
source/valu_addsub_unit.sv
source/valu_mul_unit.sv
source/valu_result_stage.sv
source/valu_top.sv
verif/valu_checker.sv
verif/valu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the vector ALU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module valu_tb -f vlog.f -o valu_sim
./obj_dir/valu_sim > sim.log 2>&1
cat sim.log

if grep -q -F '*** FAILED ***' sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"
